//--- hw/ring_pkg.sv
package ring_pkg;

   localparam int DATA_W = 64;   // one stream beat
   localparam int ID_W   = 10;   // node address

   ////////////////////
   // packet layout

   // header beat, msb first
   typedef struct packed {
      logic [3:0]      reserved;
      logic [3:0]      op;
      logic [5:0]      flags;
      logic [ID_W-1:0] dst;
      logic [ID_W-1:0] src;
      logic [ID_W-1:0] step;    // hop count, bumped at each forward
      logic [19:0]     user;
   } hdr_t;

   // stream beat as seen on the ring links
   typedef struct packed {
      logic              valid;
      logic              last;     // high on the data beat
      logic [DATA_W-1:0] data;
   } beat_t;

   typedef struct packed {
      hdr_t              hdr;
      logic [DATA_W-1:0] data;
   } packet_t;

   ////////////////////
   // routing

   // both low means drop
   typedef struct packed {
      logic process;
      logic propagate;
   } route_t;

   typedef enum logic {
      CH_A = 1'b0,
      CH_B = 1'b1
   } ch_e;

   // step value of an exhausted packet
   localparam logic [ID_W-1:0] STEP_LIMIT = '1;

   ////////////////////
   // timing

   localparam int TIMEOUT_CYCLES = 512;   // busy cycles before the link is dropped
   localparam int WDOG_W         = $clog2(TIMEOUT_CYCLES + 1);

   typedef logic [WDOG_W-1:0] wdog_cnt_t;

endpackage

//--- hw/rx_capture.sv
`timescale 1ns/1ps

module rx_capture (
   input  logic              user_clk_i,
   input  logic              user_rst_i,
   input  ring_pkg::beat_t   rx_a_i,
   input  ring_pkg::beat_t   rx_b_i,
   input  logic              pkt_take_i,
   output ring_pkg::packet_t pkt_o,
   output ring_pkg::ch_e     pkt_ch_o,
   output logic              pkt_pending_o
);

   ring_pkg::hdr_t    hdr_a_q;   // last header seen per channel
   ring_pkg::hdr_t    hdr_b_q;
   ring_pkg::packet_t pkt_q;
   ring_pkg::ch_e     ch_q;
   logic              pending_q;
   logic              data_a;
   logic              data_b;

   assign data_a = rx_a_i.valid & rx_a_i.last;
   assign data_b = rx_b_i.valid & rx_b_i.last;

   ////////////////////
   // beat storage

   always_ff @(posedge user_clk_i) begin
      if (rx_a_i.valid && !rx_a_i.last) hdr_a_q <= ring_pkg::hdr_t'(rx_a_i.data);
      if (rx_b_i.valid && !rx_b_i.last) hdr_b_q <= ring_pkg::hdr_t'(rx_b_i.data);
      if (data_a) pkt_q <= {hdr_a_q, rx_a_i.data};
      if (data_b) pkt_q <= {hdr_b_q, rx_b_i.data};   // channel B overrides A
   end

   always_ff @(posedge user_clk_i or posedge user_rst_i) begin
      if (user_rst_i) begin
         ch_q      <= ring_pkg::CH_A;
         pending_q <= 1'b0;
      end else begin
         if (pkt_take_i) pending_q <= 1'b0;
         if (data_a || data_b) pending_q <= 1'b1;   // new arrival beats a take
         if (data_b) ch_q <= ring_pkg::CH_B;
         else if (data_a) ch_q <= ring_pkg::CH_A;
      end
   end

   assign pkt_o         = pkt_q;
   assign pkt_ch_o      = ch_q;
   assign pkt_pending_o = pending_q;

endmodule

//--- hw/hdr_route.sv
`timescale 1ns/1ps

module hdr_route (
   input  ring_pkg::hdr_t            hdr_i,
   input  logic [ring_pkg::ID_W-1:0] own_id_i,
   output ring_pkg::route_t          route_o,
   output ring_pkg::hdr_t            fwd_hdr_o
);

   logic id_set;      // node has an address
   logic exhausted;
   logic dst_own;
   logic src_own;
   logic dst_all;
   logic process;

   always_comb begin
      id_set    = |own_id_i;
      exhausted = id_set & (hdr_i.step == ring_pkg::STEP_LIMIT);
      dst_own   = id_set & (hdr_i.dst == own_id_i);
      src_own   = (hdr_i.src == own_id_i);   // came back around the ring
      dst_all   = &hdr_i.dst;                // broadcast
      process   = ~exhausted & (dst_own | src_own | dst_all);

      route_o.process   = process;
      route_o.propagate = ~exhausted & ~process;
   end

   // forwarded copy differs only in the step count
   always_comb begin
      fwd_hdr_o      = hdr_i;
      fwd_hdr_o.step = hdr_i.step + 1'b1;
   end

endmodule

//--- hw/tx_beat_out.sv
`timescale 1ns/1ps

module tx_beat_out (
   input  logic                        user_clk_i,
   input  logic                        user_rst_i,
   input  logic                        load_i,
   input  logic                        use_local_i,
   input  ring_pkg::ch_e               out_ch_i,
   input  ring_pkg::packet_t           local_pkt_i,
   input  ring_pkg::hdr_t              fwd_hdr_i,
   input  logic [ring_pkg::DATA_W-1:0] fwd_data_i,
   input  logic                        tx_a_ready_i,
   input  logic                        tx_b_ready_i,
   input  logic                        abort_i,
   output ring_pkg::beat_t             tx_a_o,
   output ring_pkg::beat_t             tx_b_o,
   output logic                        hdr_done_o,
   output logic                        data_done_o
);

   ring_pkg::packet_t pkt_q;
   ring_pkg::ch_e     ch_q;
   ring_pkg::beat_t   beat;
   logic              vld_q;
   logic              data_ph_q;   // 0 header beat, 1 data beat
   logic              ready_sel;
   logic              xfer;

   assign ready_sel   = (ch_q == ring_pkg::CH_B) ? tx_b_ready_i : tx_a_ready_i;
   assign xfer        = vld_q & ready_sel;
   assign hdr_done_o  = xfer & ~data_ph_q;
   assign data_done_o = xfer & data_ph_q;

   always_ff @(posedge user_clk_i) begin
      if (load_i) pkt_q <= use_local_i ? local_pkt_i : {fwd_hdr_i, fwd_data_i};
   end

   ////////////////////
   // beat sequencing

   always_ff @(posedge user_clk_i or posedge user_rst_i) begin
      if (user_rst_i) begin
         ch_q      <= ring_pkg::CH_A;
         vld_q     <= 1'b0;
         data_ph_q <= 1'b0;
      end else if (abort_i) begin
         vld_q     <= 1'b0;
         data_ph_q <= 1'b0;
      end else if (load_i) begin
         ch_q      <= out_ch_i;
         vld_q     <= 1'b1;
         data_ph_q <= 1'b0;
      end else if (xfer) begin
         if (data_ph_q) begin
            vld_q     <= 1'b0;   // packet done
            data_ph_q <= 1'b0;
         end else begin
            data_ph_q <= 1'b1;
         end
      end
   end

   always_comb begin
      beat.valid   = vld_q;
      beat.last    = data_ph_q;
      beat.data    = data_ph_q ? pkt_q.data : pkt_q.hdr;
      tx_a_o       = beat;
      tx_b_o       = beat;
      tx_a_o.valid = vld_q & (ch_q == ring_pkg::CH_A);   // only the chosen link
      tx_b_o.valid = vld_q & (ch_q == ring_pkg::CH_B);
   end

endmodule

//--- hw/link_watchdog.sv
`timescale 1ns/1ps

module link_watchdog (
   input  logic user_clk_i,
   input  logic user_rst_i,
   input  logic busy_i,
   output logic timeout_o
);

   ring_pkg::wdog_cnt_t cnt_q;
   logic                timeout_q;

   always_ff @(posedge user_clk_i or posedge user_rst_i) begin
      if (user_rst_i) begin
         cnt_q     <= '0;
         timeout_q <= 1'b0;
      end else begin
         timeout_q <= busy_i & (cnt_q == ring_pkg::wdog_cnt_t'(ring_pkg::TIMEOUT_CYCLES - 1));
         if (!busy_i) begin
            cnt_q <= '0;
         end else if (cnt_q != ring_pkg::wdog_cnt_t'(ring_pkg::TIMEOUT_CYCLES)) begin
            cnt_q <= cnt_q + 1'b1;   // holds at the limit, one pulse only
         end
      end
   end

   assign timeout_o = timeout_q;

endmodule

//--- hw/ring_ctrl.sv
`timescale 1ns/1ps

module ring_ctrl (
   input  logic             user_clk_i,
   input  logic             user_rst_i,
   input  logic             link_up_i,
   input  logic             pkt_pending_i,
   input  ring_pkg::route_t route_i,
   input  ring_pkg::ch_e    pkt_ch_i,
   input  logic             tx_req_i,
   input  ring_pkg::ch_e    tx_ch_i,
   input  logic             hdr_done_i,
   input  logic             data_done_i,
   input  logic             timeout_i,
   output logic             pkt_take_o,
   output logic             load_o,
   output logic             use_local_o,
   output ring_pkg::ch_e    out_ch_o,
   output logic             abort_o,
   output logic             busy_o,
   output logic             cmd_req_o,
   output logic             tx_ack_o,
   output logic             ready_o
);

   typedef enum logic [2:0] {
      ST_NOT_READY,
      ST_IDLE,
      ST_ROUTE,
      ST_SEND_HDR,
      ST_SEND_DATA,
      ST_WAIT_REQ_LOW
   } state_e;

   state_e state_q;
   state_e state_nxt;
   logic   local_q;     // current send came from tx_req_i
   logic   local_nxt;
   logic   cmd_req_q;
   logic   ack_q;
   logic   link_fail;
   logic   rdy;

   assign link_fail = ~link_up_i | timeout_i;

   ////////////////////
   // next state

   always_comb begin
      state_nxt   = state_q;
      local_nxt   = local_q;
      pkt_take_o  = 1'b0;
      load_o      = 1'b0;
      use_local_o = 1'b0;
      out_ch_o    = tx_ch_i;
      case (state_q)
         ST_NOT_READY: begin
            if (link_up_i) state_nxt = ST_IDLE;
         end
         ST_IDLE: begin
            if (pkt_pending_i) begin
               state_nxt = ST_ROUTE;   // ring traffic before local requests
            end else if (tx_req_i) begin
               load_o      = 1'b1;
               use_local_o = 1'b1;
               local_nxt   = 1'b1;
               state_nxt   = ST_SEND_HDR;
            end
         end
         ST_ROUTE: begin
            pkt_take_o = 1'b1;
            if (route_i.propagate) begin
               load_o    = 1'b1;
               out_ch_o  = (pkt_ch_i == ring_pkg::CH_A) ? ring_pkg::CH_B : ring_pkg::CH_A;
               local_nxt = 1'b0;
               state_nxt = ST_SEND_HDR;
            end else begin
               state_nxt = ST_IDLE;   // process or drop
            end
         end
         ST_SEND_HDR: begin
            if (hdr_done_i) state_nxt = ST_SEND_DATA;
         end
         ST_SEND_DATA: begin
            if (data_done_i) state_nxt = local_q ? ST_WAIT_REQ_LOW : ST_IDLE;
         end
         ST_WAIT_REQ_LOW: begin
            if (!tx_req_i) state_nxt = ST_IDLE;
         end
         default: state_nxt = ST_NOT_READY;
      endcase
      if (link_fail) begin
         state_nxt = ST_NOT_READY;
         load_o    = 1'b0;
      end
   end

   ////////////////////
   // registers

   always_ff @(posedge user_clk_i or posedge user_rst_i) begin
      if (user_rst_i) begin
         state_q   <= ST_NOT_READY;
         local_q   <= 1'b0;
         cmd_req_q <= 1'b0;
         ack_q     <= 1'b0;
      end else begin
         state_q   <= state_nxt;
         local_q   <= local_nxt;
         cmd_req_q <= (state_q == ST_ROUTE) & route_i.process & ~link_fail;   // single pulse
         ack_q     <= local_nxt
                      & (state_nxt inside {ST_SEND_HDR, ST_SEND_DATA, ST_WAIT_REQ_LOW});
      end
   end

   assign rdy       = (state_q != ST_NOT_READY);
   assign ready_o   = rdy;
   assign busy_o    = rdy & (state_q != ST_IDLE);   // watchdog runs outside idle
   assign abort_o   = link_fail | ~rdy;
   assign cmd_req_o = cmd_req_q;
   assign tx_ack_o  = ack_q;

endmodule

//--- hw/ring_node_top.sv
`timescale 1ns/1ps

module ring_node_top (
   input  logic                      user_clk_i,
   input  logic                      user_rst_i,
   input  logic                      link_up_i,
   input  logic [ring_pkg::ID_W-1:0] own_id_i,
   input  ring_pkg::beat_t           rx_a_i,
   input  ring_pkg::beat_t           rx_b_i,
   input  logic                      tx_a_ready_i,
   input  logic                      tx_b_ready_i,
   input  logic                      tx_req_i,
   input  ring_pkg::ch_e             tx_ch_i,
   input  ring_pkg::packet_t         tx_pkt_i,
   output ring_pkg::beat_t           tx_a_o,
   output ring_pkg::beat_t           tx_b_o,
   output logic                      tx_ack_o,
   output logic                      cmd_req_o,
   output ring_pkg::packet_t         cmd_o,
   output ring_pkg::ch_e             cmd_ch_o,
   output logic                      ready_o
);

   ring_pkg::packet_t pkt;
   ring_pkg::ch_e     pkt_ch;
   ring_pkg::route_t  route;
   ring_pkg::hdr_t    fwd_hdr;
   ring_pkg::ch_e     out_ch;
   logic              pkt_pending;
   logic              pkt_take;
   logic              load;
   logic              use_local;
   logic              abort;
   logic              busy;
   logic              timeout;
   logic              hdr_done;
   logic              data_done;

   assign cmd_o    = pkt;      // command port shows the last captured packet
   assign cmd_ch_o = pkt_ch;

   ////////////////////
   // control

   ring_ctrl ctrl_i (
      .user_clk_i    (user_clk_i),
      .user_rst_i    (user_rst_i),
      .link_up_i     (link_up_i),
      .pkt_pending_i (pkt_pending),
      .route_i       (route),
      .pkt_ch_i      (pkt_ch),
      .tx_req_i      (tx_req_i),
      .tx_ch_i       (tx_ch_i),
      .hdr_done_i    (hdr_done),
      .data_done_i   (data_done),
      .timeout_i     (timeout),
      .pkt_take_o    (pkt_take),
      .load_o        (load),
      .use_local_o   (use_local),
      .out_ch_o      (out_ch),
      .abort_o       (abort),
      .busy_o        (busy),
      .cmd_req_o     (cmd_req_o),
      .tx_ack_o      (tx_ack_o),
      .ready_o       (ready_o)
   );

   link_watchdog wdog_i (
      .user_clk_i (user_clk_i),
      .user_rst_i (user_rst_i),
      .busy_i     (busy),
      .timeout_o  (timeout)
   );

   ////////////////////
   // datapath

   rx_capture rx_i (
      .user_clk_i    (user_clk_i),
      .user_rst_i    (user_rst_i),
      .rx_a_i        (rx_a_i),
      .rx_b_i        (rx_b_i),
      .pkt_take_i    (pkt_take),
      .pkt_o         (pkt),
      .pkt_ch_o      (pkt_ch),
      .pkt_pending_o (pkt_pending)
   );

   hdr_route route_i (
      .hdr_i     (pkt.hdr),
      .own_id_i  (own_id_i),
      .route_o   (route),
      .fwd_hdr_o (fwd_hdr)
   );

   tx_beat_out tx_i (
      .user_clk_i   (user_clk_i),
      .user_rst_i   (user_rst_i),
      .load_i       (load),
      .use_local_i  (use_local),
      .out_ch_i     (out_ch),
      .local_pkt_i  (tx_pkt_i),
      .fwd_hdr_i    (fwd_hdr),
      .fwd_data_i   (pkt.data),
      .tx_a_ready_i (tx_a_ready_i),
      .tx_b_ready_i (tx_b_ready_i),
      .abort_i      (abort),
      .tx_a_o       (tx_a_o),
      .tx_b_o       (tx_b_o),
      .hdr_done_o   (hdr_done),
      .data_done_o  (data_done)
   );

endmodule

//--- verif/ring_node_tb.sv
`timescale 1ns/1ps

module ring_node_tb;

   localparam int     CLK_PERIOD   = 40;
   localparam int     RST_CYCLES   = 16;
   localparam int     N_PROC       = 6;
   localparam int     N_PROP       = 6;
   localparam int     N_DROP       = 3;
   localparam int     N_LOCAL      = 4;
   localparam int     N_TESTS      = 1 + N_PROC + N_PROP + N_DROP + N_LOCAL;
   localparam longint RUN_LIMIT_NS = (longint'(N_TESTS) * 2000 + 1000) * CLK_PERIOD;
   localparam int     OUTCOME_WAIT = 100;   // cycles allowed for a command or a packet
   localparam int     SETTLE       = 8;     // quiet cycles after each result
   localparam int     ACK_WAIT     = 50;
   localparam int     STALL_CYCLES = 600;

   typedef logic [ring_pkg::ID_W-1:0] id_t;

   // one predicted or observed result of a test
   typedef struct packed {
      ring_pkg::route_t  route;   // process = command pulse, propagate = packet sent
      ring_pkg::packet_t pkt;
      ring_pkg::ch_e     ch;
   } outcome_t;

   localparam ring_pkg::route_t GOT_CMD = 2'b10;
   localparam ring_pkg::route_t GOT_TX  = 2'b01;

   logic              user_clk_i   = 1'b0;
   logic              user_rst_i;
   logic              link_up_i;
   id_t               own_id_i;
   ring_pkg::beat_t   rx_a_i;
   ring_pkg::beat_t   rx_b_i;
   logic              tx_a_ready_i = 1'b1;
   logic              tx_b_ready_i = 1'b1;
   logic              tx_req_i;
   ring_pkg::ch_e     tx_ch_i;
   ring_pkg::packet_t tx_pkt_i;
   ring_pkg::beat_t   tx_a_o;
   ring_pkg::beat_t   tx_b_o;
   logic              tx_ack_o;
   logic              cmd_req_o;
   ring_pkg::packet_t cmd_o;
   ring_pkg::ch_e     cmd_ch_o;
   logic              ready_o;

   outcome_t                    exp_q[$];
   outcome_t                    obs_q[$];
   string                       name_q[$];
   logic [ring_pkg::DATA_W-1:0] hdr_a_seen;
   logic [ring_pkg::DATA_W-1:0] hdr_b_seen;
   int                          ready_mode   = 0;   // 0 ready, 1 random stalls, 2 held low
   int                          err_cnt      = 0;
   int                          err_seen     = 0;
   int                          tests_run    = 0;
   int                          tests_failed = 0;
   int                          done_cnt     = 0;
   int                          n_queued     = 0;

   ring_node_top dut_i (.*);

   always #(CLK_PERIOD / 2) user_clk_i = ~user_clk_i;

   ////////////////////
   // reference model

   function automatic ring_pkg::route_t predict_route(input ring_pkg::hdr_t h, input id_t own,
                                                      output ring_pkg::hdr_t fwd);
      ring_pkg::route_t r;
      logic             exhausted;
      logic             hit;
      exhausted   = (own != '0) && (h.step == '1);
      hit         = ((own != '0) && (h.dst == own)) || (h.src == own) || (h.dst == '1);
      r.process   = !exhausted && hit;
      r.propagate = !exhausted && !hit;
      fwd         = h;
      fwd.step    = h.step + 1'b1;   // only the hop count moves
      return r;
   endfunction

   function automatic outcome_t make_outcome(input ring_pkg::route_t r,
                                             input ring_pkg::packet_t p, input ring_pkg::ch_e c);
      outcome_t o;
      o.route = r;
      o.pkt   = p;
      o.ch    = c;
      return o;
   endfunction

   function automatic ring_pkg::ch_e flip_ch(input ring_pkg::ch_e c);
      return (c == ring_pkg::CH_A) ? ring_pkg::CH_B : ring_pkg::CH_A;
   endfunction

   function automatic ring_pkg::ch_e rand_ch();
      return ($urandom_range(0, 1) == 0) ? ring_pkg::CH_A : ring_pkg::CH_B;
   endfunction

   // any address but own and broadcast
   function automatic id_t other_id(input id_t own);
      id_t id;
      id = own;
      while (id == own) id = id_t'($urandom_range(0, 1022));
      return id;
   endfunction

   function automatic ring_pkg::hdr_t rand_hdr(input id_t own);
      ring_pkg::hdr_t h;
      h      = {$urandom, $urandom};
      h.dst  = other_id(own);
      h.src  = other_id(own);
      h.step = id_t'($urandom_range(0, 1022));   // never exhausted
      return h;
   endfunction

   ////////////////////
   // compare and report

   task automatic check_packet(input string name, input ring_pkg::packet_t exp,
                               input ring_pkg::packet_t act);
      if (act !== exp) begin
         $display("FAIL %s packet: expected %h actual %h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_ch(input string name, input ring_pkg::ch_e exp, input ring_pkg::ch_e act);
      if (act !== exp) begin
         $display("FAIL %s channel: expected %0d actual %0d", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_route(input string name, input ring_pkg::route_t exp,
                              input ring_pkg::route_t act);
      if (act !== exp) begin
         $display("FAIL %s outcome: expected %b actual %b", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic report_test(input string name);
      int errs;
      errs     = err_cnt - err_seen;
      err_seen = err_cnt;
      tests_run++;
      if (errs == 0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: failed with %0d error(s)", name, errs);
         tests_failed++;
      end
   endtask

   task automatic check_link_down(input string name);
      if (ready_o || cmd_req_o || tx_ack_o || tx_a_o.valid || tx_b_o.valid) begin
         $display("test %s: node output active while the link is down", name);
         err_cnt++;
      end
   endtask

   ////////////////////
   // monitor and checker

   // beats move on valid and ready at the rising edge
   always @(posedge user_clk_i) begin
      if (cmd_req_o) obs_q.push_back(make_outcome(GOT_CMD, cmd_o, cmd_ch_o));
      if (tx_a_o.valid && tx_a_ready_i) begin
         if (!tx_a_o.last) hdr_a_seen = tx_a_o.data;
         else obs_q.push_back(make_outcome(GOT_TX, {hdr_a_seen, tx_a_o.data}, ring_pkg::CH_A));
      end
      if (tx_b_o.valid && tx_b_ready_i) begin
         if (!tx_b_o.last) hdr_b_seen = tx_b_o.data;
         else obs_q.push_back(make_outcome(GOT_TX, {hdr_b_seen, tx_b_o.data}, ring_pkg::CH_B));
      end
   end

   always @(negedge user_clk_i) begin
      case (ready_mode)
         0: begin
            tx_a_ready_i = 1'b1;
            tx_b_ready_i = 1'b1;
         end
         1: begin
            tx_a_ready_i = ($urandom_range(0, 3) != 0);
            tx_b_ready_i = ($urandom_range(0, 3) != 0);
         end
         default: begin
            tx_a_ready_i = 1'b0;
            tx_b_ready_i = 1'b0;
         end
      endcase
   end

   initial begin : result_check
      outcome_t exp;
      outcome_t obs;
      string    name;
      int       waited;
      forever begin
         @(negedge user_clk_i);
         if (exp_q.size() != 0) begin
            exp    = exp_q.pop_front();
            name   = name_q.pop_front();
            waited = 0;
            while (obs_q.size() == 0 && waited < OUTCOME_WAIT) begin
               @(negedge user_clk_i);
               waited++;
            end
            if (obs_q.size() != 0) obs = obs_q.pop_front();
            else obs = '0;   // nothing seen, a drop
            check_route(name, exp.route, obs.route);
            if (exp.route != 2'b00 && obs.route == exp.route) begin
               check_packet(name, exp.pkt, obs.pkt);
               check_ch(name, exp.ch, obs.ch);
            end
            repeat (SETTLE) @(negedge user_clk_i);
            if (obs_q.size() != 0) begin
               $display("test %s: %0d unexpected extra output(s)", name, obs_q.size());
               err_cnt++;
               obs_q.delete();
            end
            report_test(name);
            done_cnt++;
         end
      end
   end

   ////////////////////
   // stimulus tasks

   task automatic expect_outcome(input string name, input outcome_t o);
      exp_q.push_back(o);
      name_q.push_back(name);
      n_queued++;
   endtask

   task automatic wait_checked();
      while (done_cnt < n_queued) @(negedge user_clk_i);
   endtask

   task automatic drive_rx(input ring_pkg::ch_e ch, input ring_pkg::beat_t b);
      if (ch == ring_pkg::CH_B) rx_b_i = b;
      else rx_a_i = b;
   endtask

   task automatic send_ring(input ring_pkg::ch_e ch, input ring_pkg::packet_t pkt);
      ring_pkg::beat_t b;
      b.valid = 1'b1;
      b.last  = 1'b0;
      b.data  = pkt.hdr;
      drive_rx(ch, b);
      @(negedge user_clk_i);
      if ($urandom_range(0, 1) == 1) begin   // optional gap between beats
         drive_rx(ch, '0);
         @(negedge user_clk_i);
      end
      b.last = 1'b1;
      b.data = pkt.data;
      drive_rx(ch, b);
      @(negedge user_clk_i);
      drive_rx(ch, '0);
   endtask

   task automatic run_ring_test(input string name, input ring_pkg::ch_e ch,
                                input ring_pkg::packet_t pkt);
      ring_pkg::route_t r;
      ring_pkg::hdr_t   fwd;
      outcome_t         o;
      r       = predict_route(pkt.hdr, own_id_i, fwd);
      o       = '0;
      o.route = r;
      if (r.process) begin
         o.pkt = pkt;
         o.ch  = ch;
      end else if (r.propagate) begin
         o.pkt = {fwd, pkt.data};
         o.ch  = flip_ch(ch);
      end
      expect_outcome(name, o);
      send_ring(ch, pkt);
      wait_checked();
   endtask

   task automatic wait_ack_high(input string name);
      int waited;
      waited = 0;
      while (!tx_ack_o && waited < ACK_WAIT) begin
         @(negedge user_clk_i);
         waited++;
      end
      if (!tx_ack_o) begin
         $display("test %s: tx_ack_o never rose for the local request", name);
         err_cnt++;
      end
   endtask

   task automatic run_local_test(input string name, input ring_pkg::ch_e ch,
                                 input ring_pkg::packet_t pkt);
      int waited;
      expect_outcome(name, make_outcome(GOT_TX, pkt, ch));
      tx_pkt_i = pkt;
      tx_ch_i  = ch;
      tx_req_i = 1'b1;
      wait_ack_high(name);
      tx_req_i = 1'b0;
      waited   = 0;
      while (tx_ack_o && waited < ACK_WAIT) begin
         @(negedge user_clk_i);
         waited++;
      end
      if (tx_ack_o) begin
         $display("test %s: tx_ack_o stayed high after the request was lowered", name);
         err_cnt++;
      end
      wait_checked();
   endtask

   task automatic run_timeout_test(input string name, input ring_pkg::ch_e ch,
                                   input ring_pkg::packet_t pkt);
      logic saw_drop;
      ready_mode = 2;
      @(negedge user_clk_i);
      tx_pkt_i = pkt;
      tx_ch_i  = ch;
      tx_req_i = 1'b1;
      wait_ack_high(name);
      saw_drop = 1'b0;
      repeat (STALL_CYCLES) begin
         @(negedge user_clk_i);
         if (!ready_o) begin
            saw_drop = 1'b1;
            if (tx_a_o.valid || tx_b_o.valid || tx_ack_o) begin
               $display("test %s: transmit valid or tx_ack_o high while not ready", name);
               err_cnt++;
            end
         end
      end
      if (!saw_drop) begin
         $display("test %s: ready_o never fell during the stalled send", name);
         err_cnt++;
      end
      if (!ready_o) begin
         $display("test %s: node did not return to ready after the stall", name);
         err_cnt++;
      end
      // request still up, so the node sends it again once released
      expect_outcome(name, make_outcome(GOT_TX, pkt, ch));
      tx_req_i   = 1'b0;
      ready_mode = 0;
      wait_checked();
   endtask

   ////////////////////
   // test sequence

   initial begin : stimulus
      ring_pkg::packet_t pkt;
      int                waited;
      void'($urandom(32'hea37));
      user_rst_i = 1'b1;
      link_up_i  = 1'b0;
      rx_a_i     = '0;
      rx_b_i     = '0;
      tx_req_i   = 1'b0;
      tx_ch_i    = ring_pkg::CH_A;
      tx_pkt_i   = '0;
      own_id_i   = id_t'($urandom_range(1, 1022));

      repeat (RST_CYCLES) begin
         @(negedge user_clk_i);
         check_link_down("reset_link");
      end
      user_rst_i = 1'b0;
      repeat (10) begin
         @(negedge user_clk_i);
         check_link_down("reset_link");
      end
      link_up_i = 1'b1;
      waited    = 0;
      while (!ready_o && waited < 10) begin
         @(negedge user_clk_i);
         waited++;
      end
      if (!ready_o) begin
         $display("test reset_link: ready_o did not rise after link-up");
         err_cnt++;
      end
      report_test("reset_link");

      for (int i = 0; i < N_PROC; i++) begin
         pkt.hdr  = rand_hdr(own_id_i);
         pkt.data = {$urandom, $urandom};
         case (i % 3)
            0: pkt.hdr.dst = own_id_i;
            1: pkt.hdr.src = own_id_i;
            default: pkt.hdr.dst = '1;   // broadcast
         endcase
         run_ring_test($sformatf("process_%0d", i), rand_ch(), pkt);
      end

      ready_mode = 1;
      for (int i = 0; i < N_PROP; i++) begin
         pkt.hdr  = rand_hdr(own_id_i);
         pkt.data = {$urandom, $urandom};
         run_ring_test($sformatf("propagate_%0d", i), rand_ch(), pkt);
      end

      ready_mode = 0;
      for (int i = 0; i < N_DROP; i++) begin
         pkt.hdr      = rand_hdr(own_id_i);
         pkt.hdr.step = '1;
         pkt.data     = {$urandom, $urandom};
         run_ring_test($sformatf("drop_%0d", i), rand_ch(), pkt);
      end

      ready_mode = 1;
      for (int i = 0; i < N_LOCAL; i++) begin
         pkt.hdr  = {$urandom, $urandom};
         pkt.data = {$urandom, $urandom};
         run_local_test($sformatf("local_%0d", i), rand_ch(), pkt);
      end

      pkt.hdr  = {$urandom, $urandom};
      pkt.data = {$urandom, $urandom};
      run_timeout_test("stall_timeout", rand_ch(), pkt);

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   initial begin : run_limit
      #(RUN_LIMIT_NS);
      $display("run stopped by the watchdog before all tests finished");
      $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- files.f
hw/ring_pkg.sv
hw/rx_capture.sv
hw/hdr_route.sv
hw/tx_beat_out.sv
hw/link_watchdog.sv
hw/ring_ctrl.sv
hw/ring_node_top.sv
verif/ring_node_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the ring node testbench with Verilator, run it, check the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=ring_node_sim

verilator --binary --timing -f files.f --top-module ring_node_tb -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
